// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := sha_miner_tb
FILELIST := tb.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard source/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/sha_miner_checker.sv
module sha_miner_checker #(
	parameter logic [31:0] proc_index = 32'd0,
	parameter logic [31:0] num_procs = 32'd1,
	parameter int latency = 66
) (
	input logic clk,
	input logic reset_i,
	input logic load_i,
	input sha_pkg::job_t job_i,
	input logic run_i,
	input logic digest_valid_i,
	input sha_pkg::hash_state_t digest_i,
	input logic [31:0] nonce_i,
	output int errors_o,
	output int checked_o,
	output int in_flight_o
);
	import sha_pkg::*;

	typedef struct packed {
		job_t job;
		logic [31:0] nonce;
		logic [31:0] cycle; // Edge at which the DUT sampled run_i high.
	} candidate_t;

	// Round constants, the fractional cube roots of the first 64 primes.
	localparam logic [0:63][31:0] k_ref = {
		256'h428a2f98_71374491_b5c0fbcf_e9b5dba5_3956c25b_59f111f1_923f82a4_ab1c5ed5,
		256'hd807aa98_12835b01_243185be_550c7dc3_72be5d74_80deb1fe_9bdc06a7_c19bf174,
		256'he49b69c1_efbe4786_0fc19dc6_240ca1cc_2de92c6f_4a7484aa_5cb0a9dc_76f988da,
		256'h983e5152_a831c66d_b00327c8_bf597fc7_c6e00bf3_d5a79147_06ca6351_14292967,
		256'h27b70a85_2e1b2138_4d2c6dfc_53380d13_650a7354_766a0abb_81c2c92e_92722c85,
		256'ha2bfe8a1_a81a664b_c24b8b70_c76c51a3_d192e819_d6990624_f40e3585_106aa070,
		256'h19a4c116_1e376c08_2748774c_34b0bcb5_391c0cb3_4ed8aa4a_5b9cca4f_682e6ff3,
		256'h748f82ee_78a5636f_84c87814_8cc70208_90befffa_a4506ceb_bef9a3f7_c67178f2
	};

	candidate_t flight [$]; // Candidates in the order they entered round 0.
	job_t cur_job; // Last job seen on load_i.
	logic fresh; // The next run cycle is the first candidate of the job.
	logic [31:0] nonce;
	logic [31:0] cycle = 32'd0;
	int errors = 0;
	int checked = 0;

	// Second block of an 80-byte header, 64 rounds, then the feed-forward add.
	function automatic hash_state_t expected_digest(input job_t job, input logic [31:0] n_in);
		logic [31:0] w [64];
		logic [31:0] t1;
		logic [31:0] t2;
		logic [7:0][31:0] sum;
		logic [7:0][31:0] mid;
		hash_state_t s;
		w[0] = job.w1;
		w[1] = job.w2;
		w[2] = job.w3;
		w[3] = n_in; // The nonce closes the header.
		w[4] = pad_word;
		for (int n = 5; n < 15; n++) begin
			w[n] = 32'd0;
		end
		w[15] = msg_len_bits; // Low word of the 64-bit length field.
		for (int n = 16; n < 64; n++) begin
			w[n] = small_sigma1(w[n - 2]) + w[n - 7] + small_sigma0(w[n - 15]) + w[n - 16];
		end
		s = job.midstate;
		for (int n = 0; n < 64; n++) begin
			t1 = s.h + big_sigma1(s.e) + ch(s.e, s.f, s.g) + k_ref[n] + w[n];
			t2 = big_sigma0(s.a) + maj(s.a, s.b, s.c);
			s = {t1 + t2, s.a, s.b, s.c, s.d + t1, s.e, s.f, s.g}; // Words move down by one.
		end
		sum = s;
		mid = job.midstate;
		for (int n = 0; n < 8; n++) begin
			sum[n] = sum[n] + mid[n]; // Each word wraps at 2^32.
		end
		return sum;
	endfunction

	always @(posedge clk) begin : watch
		candidate_t cand;
		hash_state_t want;
		if (reset_i) begin
			flight.delete();
			fresh = 1'b0;
		end else begin
			cycle = cycle + 32'd1;
			if (digest_valid_i) begin
				if (flight.size() == 0) begin
					$display("At time %0t a digest came out with no candidate in flight.", $time);
					errors++;
				end else begin
					cand = flight.pop_front(); // Oldest candidate leaves first.
					want = expected_digest(cand.job, cand.nonce);
					checked++;
					if (cycle - cand.cycle != latency) begin
						$display("Error at time %0t: digest_valid_o latency is %0d, expected %0d",
							$time, cycle - cand.cycle, latency);
						errors++;
					end
					if (digest_i !== want) begin
						$display("Error at time %0t: digest_o is %h, expected %h",
							$time, digest_i, want);
						errors++;
					end
					if (nonce_i !== cand.nonce) begin
						$display("Error at time %0t: nonce_o is %h, expected %h",
							$time, nonce_i, cand.nonce);
						errors++;
					end
				end
			end
			if (load_i) begin
				cur_job = job_i; // The load in this cycle already counts.
				fresh = 1'b1;
			end
			if (run_i) begin
				nonce = fresh ? proc_index : nonce + num_procs; // Idle cycles keep the nonce.
				fresh = 1'b0;
				cand.job = cur_job;
				cand.nonce = nonce;
				cand.cycle = cycle;
				flight.push_back(cand);
			end
		end
		errors_o <= errors; // Counts settle one edge later for the testbench.
		checked_o <= checked;
		in_flight_o <= flight.size();
	end

endmodule

// File: bench/sha_miner_tb.sv
module sha_miner_tb;
	import sha_pkg::*;

	localparam logic [31:0] proc_index = 32'd3;
	localparam logic [31:0] num_procs = 32'd4;
	localparam int drain_limit = 200; // Well above the 66-cycle latency.

	logic clk = 1'b0;
	logic reset_i;
	logic load_i;
	job_t job_i;
	logic run_i;
	logic digest_valid_o;
	hash_state_t digest_o;
	logic [31:0] nonce_o;
	int errors;
	int checked;
	int in_flight;
	logic [31:0] lfsr = 32'd83987;
	int tests = 0;
	int fails = 0; // Timeouts and wrong digest counts.
	int runs = 0; // Candidates driven so far.
	int runs_base = 0;
	int checked_base = 0;
	int errors_base = 0;
	int fails_base = 0;

	always #5 clk = ~clk;

	sha_miner_top #(
		.proc_index(proc_index),
		.num_procs(num_procs)
	) dut_i (
		.clk(clk),
		.reset_i(reset_i),
		.load_i(load_i),
		.job_i(job_i),
		.run_i(run_i),
		.digest_valid_o(digest_valid_o),
		.digest_o(digest_o),
		.nonce_o(nonce_o)
	);

	sha_miner_checker #(
		.proc_index(proc_index),
		.num_procs(num_procs)
	) chk (
		.clk(clk),
		.reset_i(reset_i),
		.load_i(load_i),
		.job_i(job_i),
		.run_i(run_i),
		.digest_valid_i(digest_valid_o),
		.digest_i(digest_o),
		.nonce_i(nonce_o),
		.errors_o(errors),
		.checked_o(checked),
		.in_flight_o(in_flight)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1); // Taps 32, 30, 26 and 25.
	endfunction

	function automatic logic random_bit();
		lfsr = lfsr_next(lfsr); // One step for each bit taken.
		return lfsr[0];
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], random_bit()};
		end
		return v;
	endfunction

	function automatic job_t random_job();
		logic [10:0][31:0] words;
		for (int i = 0; i < 11; i++) begin
			words[i] = random_bits(32);
		end
		return words;
	endfunction

	task automatic drive_cycle(input logic load, input job_t job, input logic run);
		@(posedge clk);
		load_i <= load;
		job_i <= job;
		run_i <= run;
		if (run) begin
			runs++;
		end
	endtask

	// Waits until every candidate has left, then prints the line for the test.
	task automatic close_test(input string name);
		int waited;
		int new_runs;
		int new_checked;
		waited = 0;
		drive_cycle(1'b0, job_i, 1'b0);
		repeat (2) @(posedge clk); // The last candidate reaches the checker queue.
		while (in_flight != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		if (in_flight != 0) begin
			$display("Test %s timed out with %0d candidates still in the pipeline.",
				name, in_flight);
			fails++;
		end
		new_runs = runs - runs_base;
		new_checked = checked - checked_base;
		if (new_checked != new_runs) begin
			$display("Test %s gave %0d digests for %0d candidates.", name, new_checked, new_runs);
			fails++;
		end
		$display("Test %s: %0d candidates, %0d digests checked, %0d failures", name, new_runs,
			new_checked, errors - errors_base + fails - fails_base);
		tests++;
		runs_base = runs;
		checked_base = checked;
		errors_base = errors;
		fails_base = fails;
	endtask

	initial begin
		job_t job;
		int target;
		int taken;
		logic run_bit;
		reset_i = 1'b1;
		load_i = 1'b0;
		job_i = '0;
		run_i = 1'b0;
		repeat (4) @(posedge clk);
		reset_i <= 1'b0;

		repeat (100) drive_cycle(1'b0, job_i, 1'b0); // Nothing may leave while idle.
		close_test("reset");

		drive_cycle(1'b1, random_job(), 1'b1); // One candidate, nonce 3.
		close_test("single");

		drive_cycle(1'b1, random_job(), 1'b1);
		repeat (39) drive_cycle(1'b0, job_i, 1'b1);
		close_test("continuous");

		// The second load lands while the first job is still in the rounds.
		drive_cycle(1'b1, random_job(), 1'b1);
		repeat (24) drive_cycle(1'b0, job_i, 1'b1);
		drive_cycle(1'b1, random_job(), 1'b1);
		repeat (20) drive_cycle(1'b0, job_i, 1'b1);
		close_test("reload");

		for (int j = 0; j < 6; j++) begin
			job = random_job();
			run_bit = random_bit();
			drive_cycle(1'b1, job, run_bit); // Loads come with or without a candidate.
			target = 20 + random_bits(4); // Keeps loads apart by more than 15 cycles.
			taken = 0;
			while (taken < target) begin
				run_bit = random_bit(); // About half the cycles are gaps.
				drive_cycle(1'b0, job_i, run_bit);
				if (run_bit) begin
					taken++;
				end
			end
		end
		close_test("random");

		$display("Tests: %0d, candidates: %0d, digests checked: %0d, failures: %0d",
			tests, runs, checked, errors + fails);
		if (errors == 0 && fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: source/nonce_counter.sv
module nonce_counter #(
	parameter logic [31:0] proc_index = 32'd0,
	parameter logic [31:0] num_procs = 32'd1
) (
	input logic clk,
	input logic restart_i,
	input logic step_i,
	output logic [31:0] count_o
);

	// Each job start loads the first nonce again.
	always_ff @(posedge clk) begin
		if (restart_i) begin
			count_o <= proc_index; // First nonce of this core.
		end else if (step_i) begin
			count_o <= count_o + num_procs; // Skip over the nonces of the other cores.
		end
	end

	// Restart is a newblock candidate, which is also a valid one in the stage
	// that drives both inputs.
	restart_with_step: assert property (
		@(posedge clk) restart_i |-> step_i
	) else $error("nonce counter restarted without a candidate");

endmodule

// File: source/sha_job_regs.sv
module sha_job_regs (
	input logic clk,
	input logic reset_i,
	input logic load_i,
	input sha_pkg::job_t job_i,
	input logic run_i,
	output sha_pkg::job_t job_o,
	output sha_pkg::round_ctl_t ctl_o
);

	logic pending; // A job was loaded and no candidate of it has entered yet.
	logic first_of_job;

	assign first_of_job = pending | load_i; // A load in this cycle also counts.

	// The job words steer the front stages directly, so they change only on a load.
	always_ff @(posedge clk) begin
		if (load_i) begin
			job_o <= job_i; // Visible in the same cycle as the newblock strobe.
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pending <= 1'b0;
			ctl_o <= '0;
		end else begin
			ctl_o.valid <= run_i; // One candidate per cycle while the job runs.
			ctl_o.newblock <= run_i & first_of_job; // Marks the first candidate of the job.
			pending <= first_of_job & ~run_i; // Kept across idle cycles until a run cycle.
		end
	end

	// Once a candidate of the job has entered, the pending flag is clear, so only
	// a new load can mark another job start.
	newblock_once: assert property (
		@(posedge clk) disable iff (reset_i)
		ctl_o.valid && !load_i |=> !ctl_o.newblock
	) else $error("newblock strobe repeated without a new load");

endmodule

// File: source/sha_main_pipeline.sv
module sha_main_pipeline (
	input logic clk,
	input logic reset_i,
	input sha_pkg::round_ctl_t ctl_i,
	input sha_pkg::hash_state_t state_i,
	input sha_pkg::schedule_t history_i,
	input sha_pkg::hash_state_t midstate_i,
	input logic [31:0] nonce_i,
	output logic digest_valid_o,
	output sha_pkg::hash_state_t digest_o,
	output logic [31:0] nonce_o
);
	import sha_pkg::*;

	localparam int first_round = 15; // Rounds 0 to 14 ran in the pre-pipeline.
	localparam int num_stages = 49;

	round_ctl_t ctl_pipe [num_stages + 1]; // Index i is the input of round 15 + i.
	hash_state_t state_pipe [num_stages + 1];
	hash_state_t mid_pipe [num_stages + 1];
	logic [31:0] nonce_pipe [num_stages + 1];
	schedule_t win_pipe [num_stages]; // Word 0 of entry i is W[15 + i].

	assign ctl_pipe[0] = ctl_i;
	assign state_pipe[0] = state_i;
	assign mid_pipe[0] = midstate_i;
	assign nonce_pipe[0] = nonce_i;
	assign win_pipe[0] = history_i; // W0 to W15 on entry.

	for (genvar i = 0; i < num_stages; i++) begin : g_round
		sha_round_stage #(
			.k(k_const(first_round + i))
		) stage (
			.clk(clk),
			.reset_i(reset_i),
			.state_i(state_pipe[i]),
			.w_i(win_pipe[i][0]), // The newest window word belongs to this round.
			.ctl_i(ctl_pipe[i]),
			.state_o(state_pipe[i + 1]),
			.ctl_o(ctl_pipe[i + 1])
		);

		always_ff @(posedge clk) begin
			mid_pipe[i + 1] <= mid_pipe[i]; // The midstate and nonce follow their candidate.
			nonce_pipe[i + 1] <= nonce_pipe[i];
		end
	end

	// Round 63 needs no further word, so one window register fewer than rounds.
	for (genvar i = 0; i < num_stages - 1; i++) begin : g_window
		logic [31:0] w_next;

		// W[r+1] from W[r-1], W[r-6], W[r-14] and W[r-15], with r = 15 + i.
		assign w_next = small_sigma1(win_pipe[i][1]) + win_pipe[i][6]
			+ small_sigma0(win_pipe[i][14]) + win_pipe[i][15];

		always_ff @(posedge clk) begin
			win_pipe[i + 1] <= {win_pipe[i][14:0], w_next}; // Drop the oldest word.
		end
	end

	// Feed-forward add of the midstate, each word modulo 2^32.
	always_ff @(posedge clk) begin
		digest_o.a <= state_pipe[num_stages].a + mid_pipe[num_stages].a;
		digest_o.b <= state_pipe[num_stages].b + mid_pipe[num_stages].b;
		digest_o.c <= state_pipe[num_stages].c + mid_pipe[num_stages].c;
		digest_o.d <= state_pipe[num_stages].d + mid_pipe[num_stages].d;
		digest_o.e <= state_pipe[num_stages].e + mid_pipe[num_stages].e;
		digest_o.f <= state_pipe[num_stages].f + mid_pipe[num_stages].f;
		digest_o.g <= state_pipe[num_stages].g + mid_pipe[num_stages].g;
		digest_o.h <= state_pipe[num_stages].h + mid_pipe[num_stages].h;
		nonce_o <= nonce_pipe[num_stages]; // Leaves with its digest.
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			digest_valid_o <= 1'b0;
		end else begin
			digest_valid_o <= ctl_pipe[num_stages].valid;
		end
	end

endmodule

// File: source/sha_miner_top.sv
module sha_miner_top #(
	parameter logic [31:0] proc_index = 32'd0,
	parameter logic [31:0] num_procs = 32'd1
) (
	input logic clk,
	input logic reset_i,
	input logic load_i,
	input sha_pkg::job_t job_i,
	input logic run_i,
	output logic digest_valid_o,
	output sha_pkg::hash_state_t digest_o,
	output logic [31:0] nonce_o
);
	import sha_pkg::*;

	job_t job; // Current job, held between loads.
	round_ctl_t entry_ctl; // Strobes of the candidate entering round 0.
	round_ctl_t mid_ctl; // Strobes of the candidate entering round 15.
	hash_state_t mid_state;
	schedule_t mid_history;
	hash_state_t mid_midstate;
	logic [31:0] mid_nonce;

	sha_job_regs job_regs (
		.clk(clk),
		.reset_i(reset_i),
		.load_i(load_i),
		.job_i(job_i),
		.run_i(run_i),
		.job_o(job),
		.ctl_o(entry_ctl)
	);

	sha_pre_pipeline #(
		.proc_index(proc_index),
		.num_procs(num_procs)
	) pre (
		.clk(clk),
		.reset_i(reset_i),
		.job_i(job),
		.ctl_i(entry_ctl),
		.ctl_o(mid_ctl),
		.state_o(mid_state),
		.history_o(mid_history),
		.midstate_o(mid_midstate),
		.nonce_o(mid_nonce)
	);

	sha_main_pipeline main (
		.clk(clk),
		.reset_i(reset_i),
		.ctl_i(mid_ctl),
		.state_i(mid_state),
		.history_i(mid_history),
		.midstate_i(mid_midstate),
		.nonce_i(mid_nonce),
		.digest_valid_o(digest_valid_o),
		.digest_o(digest_o),
		.nonce_o(nonce_o)
	);

endmodule

// File: source/sha_pkg.sv
package sha_pkg;

	// The eight SHA-256 working variables a to h.
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;
		logic [31:0] g;
		logic [31:0] h;
	} hash_state_t;

	typedef struct packed {
		hash_state_t midstate; // State after the first 64-byte block of the header.
		logic [31:0] w1; // Header words 16 to 18, the start of the second block.
		logic [31:0] w2;
		logic [31:0] w3;
	} job_t;

	typedef struct packed {
		logic valid; // A candidate occupies this stage.
		logic newblock; // First candidate of a new job.
	} round_ctl_t;

	typedef logic [15:0][31:0] schedule_t; // Word 0 is the newest message word.

	localparam logic [31:0] msg_len_bits = 32'd640; // An 80-byte header is 640 bits long.
	localparam logic [31:0] pad_word = 32'h80000000; // The single one bit after the message.

	// Round constants, index 0 sits in the leftmost word.
	localparam logic [0:63][31:0] k_table = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic logic [31:0] k_const(input int idx);
		return k_table[idx[5:0]]; // Only 64 rounds exist.
	endfunction

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n)); // Rotate right by n bits.
	endfunction

	function automatic logic [31:0] big_sigma0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] big_sigma1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [31:0] small_sigma0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3); // Shift, not rotate, in the last term.
	endfunction

	function automatic logic [31:0] small_sigma1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic logic [31:0] ch(input logic [31:0] x, input logic [31:0] y,
			input logic [31:0] z);
		return (x & y) ^ (~x & z); // The bits of x pick y or z.
	endfunction

	function automatic logic [31:0] maj(input logic [31:0] x, input logic [31:0] y,
			input logic [31:0] z);
		return (x & y) ^ (x & z) ^ (y & z); // Bitwise majority vote.
	endfunction

endpackage

// File: source/sha_pre_pipeline.sv
module sha_pre_pipeline #(
	parameter logic [31:0] proc_index = 32'd0,
	parameter logic [31:0] num_procs = 32'd1
) (
	input logic clk,
	input logic reset_i,
	input sha_pkg::job_t job_i,
	input sha_pkg::round_ctl_t ctl_i,
	output sha_pkg::round_ctl_t ctl_o,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::schedule_t history_o,
	output sha_pkg::hash_state_t midstate_o,
	output logic [31:0] nonce_o
);
	import sha_pkg::*;

	round_ctl_t ctl_pipe [16]; // Index i is the input of round i.
	hash_state_t state_pipe [16];
	hash_state_t mid_pipe [16];
	logic [31:0] msg [15]; // Message word i, aligned with round i.
	logic [31:0] w3_q;
	logic [31:0] w1_h; // Copies of the job words for the stage 15 history.
	logic [31:0] w2_h;
	logic [31:0] w3_h;
	logic [31:0] nonce_h;
	logic hist_load;

	assign ctl_pipe[0] = ctl_i;
	assign state_pipe[0] = job_i.midstate; // Round 0 starts from the midstate.
	assign mid_pipe[0] = job_i.midstate;

	assign ctl_o = ctl_pipe[15];
	assign state_o = state_pipe[15];
	assign midstate_o = mid_pipe[15];
	assign nonce_o = nonce_h;

	assign msg[0] = job_i.w1; // Used in the entry cycle, no delay.

	always_ff @(posedge clk) begin
		msg[1] <= job_i.w2; // One cycle late, for round 1.
	end

	// w3 is taken while the job's first candidate is in round 1, then held
	// for the whole job.
	always_ff @(posedge clk) begin
		if (ctl_pipe[1].valid && ctl_pipe[1].newblock) begin
			w3_q <= job_i.w3;
		end
	end
	assign msg[2] = w3_q;

	nonce_counter #(
		.proc_index(proc_index),
		.num_procs(num_procs)
	) msg_nonce (
		.clk(clk),
		.restart_i(ctl_pipe[2].valid & ctl_pipe[2].newblock), // Count is ready for round 3.
		.step_i(ctl_pipe[2].valid), // Idle cycles use no nonce.
		.count_o(msg[3])
	);

	assign msg[4] = pad_word;
	for (genvar n = 5; n < 15; n++) begin : g_zero
		assign msg[n] = 32'd0; // Padding zeros up to the length word.
	end

	// Reloaded when a new job's first candidate is in round 14, so the new words
	// reach the history together with that candidate.
	assign hist_load = ctl_pipe[14].valid & ctl_pipe[14].newblock;

	always_ff @(posedge clk) begin
		if (hist_load) begin
			w1_h <= job_i.w1;
			w2_h <= job_i.w2;
			w3_h <= job_i.w3;
		end
	end

	nonce_counter #(
		.proc_index(proc_index),
		.num_procs(num_procs)
	) hist_nonce (
		.clk(clk),
		.restart_i(hist_load),
		.step_i(ctl_pipe[14].valid), // Same steps as msg_nonce, 12 cycles later.
		.count_o(nonce_h)
	);

	always_comb begin
		history_o[15] = w1_h; // Oldest word, W0.
		history_o[14] = w2_h;
		history_o[13] = w3_h;
		history_o[12] = nonce_h;
		for (int n = 4; n < 15; n++) begin
			history_o[15 - n] = msg[n]; // Constant padding words.
		end
		history_o[0] = msg_len_bits; // W15, the newest word.
	end

	for (genvar i = 0; i < 15; i++) begin : g_round
		sha_round_stage #(
			.k(k_const(i))
		) stage (
			.clk(clk),
			.reset_i(reset_i),
			.state_i(state_pipe[i]),
			.w_i(msg[i]),
			.ctl_i(ctl_pipe[i]),
			.state_o(state_pipe[i + 1]),
			.ctl_o(ctl_pipe[i + 1])
		);

		always_ff @(posedge clk) begin
			mid_pipe[i + 1] <= mid_pipe[i]; // Midstate rides along for the final add.
		end
	end

	out_newblock_valid: assert property (
		@(posedge clk) disable iff (reset_i)
		ctl_o.newblock |-> ctl_o.valid
	) else $error("pre-pipeline output newblock without valid");

	// The history nonce must be the one that round 3 used twelve cycles before.
	nonce_aligned: assert property (
		@(posedge clk) disable iff (reset_i)
		$past(ctl_pipe[3].valid, 12) |-> nonce_h == $past(msg[3], 12)
	) else $error("history nonce out of step with round 3 nonce");

endmodule

// File: source/sha_round_stage.sv
module sha_round_stage #(
	parameter logic [31:0] k = 32'h0
) (
	input logic clk,
	input logic reset_i,
	input sha_pkg::hash_state_t state_i,
	input logic [31:0] w_i,
	input sha_pkg::round_ctl_t ctl_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::round_ctl_t ctl_o
);
	import sha_pkg::*;

	logic [31:0] t1;
	logic [31:0] t2;

	always_comb begin
		t1 = state_i.h + big_sigma1(state_i.e) + ch(state_i.e, state_i.f, state_i.g)
			+ k + w_i; // Round constant and message word enter here.
		t2 = big_sigma0(state_i.a) + maj(state_i.a, state_i.b, state_i.c);
	end

	always_ff @(posedge clk) begin
		state_o.a <= t1 + t2; // New head of the a chain.
		state_o.b <= state_i.a;
		state_o.c <= state_i.b;
		state_o.d <= state_i.c;
		state_o.e <= state_i.d + t1; // New head of the e chain.
		state_o.f <= state_i.e;
		state_o.g <= state_i.f;
		state_o.h <= state_i.g;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctl_o <= '0;
		end else begin
			ctl_o <= ctl_i; // Strobes move in step with the state.
		end
	end

endmodule

// File: tb.f
source/sha_pkg.sv
source/sha_job_regs.sv
source/nonce_counter.sv
source/sha_round_stage.sv
source/sha_pre_pipeline.sv
source/sha_main_pipeline.sv
source/sha_miner_top.sv
bench/sha_miner_checker.sv
bench/sha_miner_tb.sv
